// ==== hdl/sb_defs.svh ====
`ifndef SB_DEFS_SVH
`define SB_DEFS_SVH

// function units, numbered 1 to SB_NUM_FU
`define SB_NUM_FU 5

// architectural registers
`define SB_NUM_REGS 32
`define SB_REG_W 5

// unit id, 0 means none
`define SB_FU_W 3

// per-unit operation code
`define SB_OP_W 5

`define SB_INST_W 32

`endif

// ==== hdl/sb_pkg.sv ====
`include "sb_defs.svh"

package sb_pkg;

    typedef logic [`SB_REG_W-1:0] reg_idx_t;
    typedef logic [`SB_FU_W-1:0] fu_id_t;
    typedef logic [`SB_OP_W-1:0] op_code_t;
    typedef logic [`SB_INST_W-1:0] inst_t;

    localparam fu_id_t FU_NONE = fu_id_t'(0);
    localparam fu_id_t FU_ALU = fu_id_t'(1);
    localparam fu_id_t FU_MEM = fu_id_t'(2);
    localparam fu_id_t FU_MUL = fu_id_t'(3);
    localparam fu_id_t FU_DIV = fu_id_t'(4);
    localparam fu_id_t FU_JUMP = fu_id_t'(5);

    typedef struct packed {
        fu_id_t   fu;
        op_code_t op;
        reg_idx_t dst;
        reg_idx_t src1;
        reg_idx_t src2;
    } decoded_t;

    typedef struct packed {
        logic     busy;
        op_code_t op;
        reg_idx_t dst;
        reg_idx_t src1;
        reg_idx_t src2;
        fu_id_t   prod1;
        fu_id_t   prod2;
        logic     rdy1;
        logic     rdy2;
        logic     done;
    } fu_entry_t;

    typedef struct packed {
        fu_id_t   fu;
        op_code_t op;
        reg_idx_t rs1;
        reg_idx_t rs2;
    } ro_t;

    typedef struct packed {
        fu_id_t   fu;
        reg_idx_t rd;
    } wb_t;

    // fixed priority JUMP, ALU, MEM, MUL, DIV over a per-unit request vector
    function automatic logic [`SB_NUM_FU-1:0] prio_pick(input logic [`SB_NUM_FU-1:0] req);
        logic [`SB_NUM_FU-1:0] gnt;
        int idx;
        gnt = '0;
        for (int k = 0; k < `SB_NUM_FU; k++) begin
            // k = 0 maps to the jump unit, then ALU upwards
            idx = (k + `SB_NUM_FU - 1) % `SB_NUM_FU;
            if (req[idx] && gnt == '0) begin
                gnt[idx] = 1'b1;
            end
        end
        return gnt;
    endfunction

endpackage

// ==== hdl/inst_decoder.sv ====
`timescale 1ns/1ns
`include "sb_defs.svh"

module inst_decoder (
    input  sb_pkg::inst_t    inst,
    output sb_pkg::decoded_t dec
);

    localparam logic [6:0] OPC_R      = 7'b0110011;
    localparam logic [6:0] OPC_I      = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    // op numbers indexed by funct3
    localparam sb_pkg::op_code_t R_ALU_OP [8] =
        '{5'd0, 5'd5, 5'd7, 5'd8, 5'd4, 5'd6, 5'd3, 5'd2};
    localparam sb_pkg::op_code_t I_ALU_OP [8] =
        '{5'd12, 5'd16, 5'd18, 5'd19, 5'd15, 5'd17, 5'd14, 5'd13};
    localparam sb_pkg::op_code_t LD_OP [8] =
        '{5'd0, 5'd1, 5'd2, 5'd0, 5'd3, 5'd4, 5'd0, 5'd0};
    localparam sb_pkg::op_code_t BR_OP [8] =
        '{5'd0, 5'd1, 5'd0, 5'd0, 5'd2, 5'd3, 5'd4, 5'd5};

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    sb_pkg::fu_id_t   fu;
    sb_pkg::op_code_t op;
    logic             use_rd;
    logic             use_rs1;
    logic             use_rs2;
    logic             valid;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        fu      = sb_pkg::FU_NONE;
        op      = '0;
        use_rd  = 1'b0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        case (opcode)
            OPC_R: begin
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                if (funct7 == 7'h01) begin
                    // upper half of funct3 selects divide
                    fu = funct3[2] ? sb_pkg::FU_DIV : sb_pkg::FU_MUL;
                    op = sb_pkg::op_code_t'(funct3[1:0]);
                end else if (funct7 == 7'h00) begin
                    fu = sb_pkg::FU_ALU;
                    op = R_ALU_OP[funct3];
                end else if (funct7 == 7'h20 && (funct3 == 3'd0 || funct3 == 3'd5)) begin
                    // sub / sra
                    fu = sb_pkg::FU_ALU;
                    op = funct3[2] ? 5'd9 : 5'd1;
                end
            end
            OPC_I: begin
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
                if (funct3[1:0] != 2'b01 || funct7 == 7'h00) begin
                    fu = sb_pkg::FU_ALU;
                    op = I_ALU_OP[funct3];
                end else if (funct3 == 3'd5 && funct7 == 7'h20) begin
                    fu = sb_pkg::FU_ALU;
                    op = 5'd20;
                end
            end
            OPC_LOAD: begin
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
                if (funct3 != 3'd3 && funct3 < 3'd6) begin
                    fu = sb_pkg::FU_MEM;
                    op = LD_OP[funct3];
                end
            end
            OPC_STORE: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                if (funct3 < 3'd3) begin
                    fu = sb_pkg::FU_MEM;
                    op = 5'd5 + funct3;
                end
            end
            OPC_BRANCH: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                if (funct3[2:1] != 2'b01) begin
                    fu = sb_pkg::FU_JUMP;
                    op = BR_OP[funct3];
                end
            end
            OPC_LUI: begin
                use_rd = 1'b1;
                fu     = sb_pkg::FU_ALU;
                op     = 5'd10;
            end
            OPC_AUIPC: begin
                use_rd = 1'b1;
                fu     = sb_pkg::FU_ALU;
                op     = 5'd11;
            end
            OPC_JAL: begin
                use_rd = 1'b1;
                fu     = sb_pkg::FU_JUMP;
                op     = 5'd6;
            end
            OPC_JALR: begin
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
                if (funct3 == 3'd0) begin
                    fu = sb_pkg::FU_JUMP;
                    op = 5'd7;
                end
            end
            default: begin
                fu = sb_pkg::FU_NONE;
            end
        endcase
    end

    // unrecognised words carry no registers
    assign valid    = (fu != sb_pkg::FU_NONE);
    assign dec.fu   = fu;
    assign dec.op   = valid ? op : '0;
    assign dec.dst  = (valid && use_rd) ? inst[11:7] : '0;
    assign dec.src1 = (valid && use_rs1) ? inst[19:15] : '0;
    assign dec.src2 = (valid && use_rs2) ? inst[24:20] : '0;

endmodule

// ==== hdl/reg_status.sv ====
`timescale 1ns/1ns
`include "sb_defs.svh"

module reg_status (
    input  logic             clk,
    input  logic             rst,
    input  sb_pkg::reg_idx_t src1,
    input  sb_pkg::reg_idx_t src2,
    input  sb_pkg::reg_idx_t dst,
    output sb_pkg::fu_id_t   prod1,
    output sb_pkg::fu_id_t   prod2,
    output sb_pkg::fu_id_t   dst_prod,
    input  logic             issue_en,
    input  sb_pkg::fu_id_t   issue_fu,
    input  sb_pkg::fu_id_t   retire_fu,
    input  sb_pkg::reg_idx_t retire_rd
);

    // pending producer per register
    sb_pkg::fu_id_t prod_q [`SB_NUM_REGS];

    assign prod1    = prod_q[src1];
    assign prod2    = prod_q[src2];
    assign dst_prod = prod_q[dst];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int r = 0; r < `SB_NUM_REGS; r++) begin
                prod_q[r] <= sb_pkg::FU_NONE;
            end
        end else begin
            if (retire_fu != sb_pkg::FU_NONE) begin
                prod_q[retire_rd] <= sb_pkg::FU_NONE;
            end
            // WAW stall keeps issue and retire on different registers
            if (issue_en && dst != '0) begin
                prod_q[dst] <= issue_fu;
            end
        end
    end

    a_x0_never_pending: assert property (@(posedge clk) disable iff (rst)
        prod_q[0] == sb_pkg::FU_NONE);

endmodule

// ==== hdl/fu_status.sv ====
`timescale 1ns/1ns
`include "sb_defs.svh"

module fu_status #(
    parameter sb_pkg::fu_id_t FU_ID = sb_pkg::FU_ALU
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              issue_en,
    input  sb_pkg::decoded_t  dec,
    input  sb_pkg::fu_id_t    prod1,
    input  sb_pkg::fu_id_t    prod2,
    input  logic              grant,
    input  logic              done,
    input  logic              retire,
    input  sb_pkg::fu_id_t    retire_fu,
    output sb_pkg::fu_entry_t entry
);

    sb_pkg::fu_entry_t entry_q;
    logic              load;
    logic              issue_rdy1;
    logic              issue_rdy2;
    logic              wake1;
    logic              wake2;

    assign load = issue_en && (dec.fu == FU_ID);

    // a producer retiring in the issue cycle counts as already written
    assign issue_rdy1 = (prod1 == sb_pkg::FU_NONE) || (prod1 == retire_fu);
    assign issue_rdy2 = (prod2 == sb_pkg::FU_NONE) || (prod2 == retire_fu);

    // RAW release from the write-back broadcast
    assign wake1 = (entry_q.prod1 != sb_pkg::FU_NONE) && (entry_q.prod1 == retire_fu);
    assign wake2 = (entry_q.prod2 != sb_pkg::FU_NONE) && (entry_q.prod2 == retire_fu);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            entry_q <= '0;
        end else if (retire) begin
            entry_q <= '0;
        end else if (load) begin
            entry_q.busy  <= 1'b1;
            entry_q.op    <= dec.op;
            entry_q.dst   <= dec.dst;
            entry_q.src1  <= dec.src1;
            entry_q.src2  <= dec.src2;
            entry_q.prod1 <= issue_rdy1 ? sb_pkg::FU_NONE : prod1;
            entry_q.prod2 <= issue_rdy2 ? sb_pkg::FU_NONE : prod2;
            entry_q.rdy1  <= issue_rdy1;
            entry_q.rdy2  <= issue_rdy2;
            entry_q.done  <= 1'b0;
        end else begin
            if (grant) begin
                entry_q.rdy1 <= 1'b0;
                entry_q.rdy2 <= 1'b0;
            end
            // producer dropped so a later retire of that unit cannot wake it twice
            if (wake1) begin
                entry_q.rdy1  <= 1'b1;
                entry_q.prod1 <= sb_pkg::FU_NONE;
            end
            if (wake2) begin
                entry_q.rdy2  <= 1'b1;
                entry_q.prod2 <= sb_pkg::FU_NONE;
            end
            if (done) begin
                entry_q.done <= 1'b1;
            end
        end
    end

    assign entry = entry_q;

    a_done_when_busy: assert property (@(posedge clk) disable iff (rst)
        done |-> entry_q.busy);

    a_issue_to_free: assert property (@(posedge clk) disable iff (rst)
        load |-> !entry_q.busy);

endmodule

// ==== hdl/issue_ctrl.sv ====
`timescale 1ns/1ns
`include "sb_defs.svh"

module issue_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  inst_valid,
    input  sb_pkg::decoded_t      dec,
    input  sb_pkg::fu_id_t        dst_prod,
    input  logic [`SB_NUM_FU-1:0] busy,
    input  logic                  jump_done,
    input  logic                  jump_taken,
    output logic                  inst_ready,
    output logic                  issue_en,
    output logic                  flush
);

    logic jump_stall_q;
    logic flush_q;
    logic unit_busy;
    logic waw;
    logic stall;

    // structural hazard on the target unit
    always_comb begin
        unit_busy = 1'b0;
        for (int i = 0; i < `SB_NUM_FU; i++) begin
            if (dec.fu == sb_pkg::fu_id_t'(i + 1)) begin
                unit_busy = busy[i];
            end
        end
    end

    assign waw   = (dec.dst != '0) && (dst_prod != sb_pkg::FU_NONE);
    assign stall = unit_busy || waw || jump_stall_q;

    // flush cycle swallows whatever is presented
    assign inst_ready = flush_q || !stall;
    assign issue_en   = inst_valid && !flush_q && !stall && (dec.fu != sb_pkg::FU_NONE);
    assign flush      = flush_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            jump_stall_q <= 1'b0;
            flush_q      <= 1'b0;
        end else begin
            if (issue_en && dec.fu == sb_pkg::FU_JUMP) begin
                jump_stall_q <= 1'b1;
            end else if (jump_done) begin
                jump_stall_q <= 1'b0;
            end
            flush_q <= jump_done && jump_taken;
        end
    end

endmodule

// ==== hdl/read_arbiter.sv ====
`timescale 1ns/1ns
`include "sb_defs.svh"

module read_arbiter (
    input  sb_pkg::fu_entry_t [`SB_NUM_FU-1:0] entries,
    output logic [`SB_NUM_FU-1:0]              grant,
    output logic                               ro_valid,
    output sb_pkg::ro_t                        ro
);

    logic [`SB_NUM_FU-1:0] req;

    // both operands available and not yet read
    always_comb begin
        for (int i = 0; i < `SB_NUM_FU; i++) begin
            req[i] = entries[i].rdy1 && entries[i].rdy2;
        end
    end

    assign grant    = sb_pkg::prio_pick(req);
    assign ro_valid = |grant;

    always_comb begin
        ro = '0;
        for (int i = 0; i < `SB_NUM_FU; i++) begin
            if (grant[i]) begin
                ro.fu  = sb_pkg::fu_id_t'(i + 1);
                ro.op  = entries[i].op;
                ro.rs1 = entries[i].src1;
                ro.rs2 = entries[i].src2;
            end
        end
    end

    a_grant_onehot: assert final ($onehot0(grant));

endmodule

// ==== hdl/writeback_ctrl.sv ====
`timescale 1ns/1ns
`include "sb_defs.svh"

module writeback_ctrl (
    input  sb_pkg::fu_entry_t [`SB_NUM_FU-1:0] entries,
    output logic [`SB_NUM_FU-1:0]              retire,
    output sb_pkg::fu_id_t                     retire_fu,
    output logic                               wb_valid,
    output sb_pkg::wb_t                        wb
);

    logic [`SB_NUM_FU-1:0] qualified;

    // WAR check holds a finished unit while another entry has yet to read its rd
    always_comb begin
        qualified = '0;
        for (int i = 0; i < `SB_NUM_FU; i++) begin
            qualified[i] = entries[i].done;
            for (int j = 0; j < `SB_NUM_FU; j++) begin
                if (j != i && entries[j].busy &&
                    ((entries[j].rdy1 && entries[j].src1 == entries[i].dst) ||
                     (entries[j].rdy2 && entries[j].src2 == entries[i].dst))) begin
                    qualified[i] = 1'b0;
                end
            end
        end
    end

    // one retirement per cycle
    assign retire   = sb_pkg::prio_pick(qualified);
    assign wb_valid = |retire;

    always_comb begin
        retire_fu = sb_pkg::FU_NONE;
        wb        = '0;
        for (int i = 0; i < `SB_NUM_FU; i++) begin
            if (retire[i]) begin
                retire_fu = sb_pkg::fu_id_t'(i + 1);
                wb.fu     = sb_pkg::fu_id_t'(i + 1);
                wb.rd     = entries[i].dst;
            end
        end
    end

endmodule

// ==== hdl/scoreboard_top.sv ====
`timescale 1ns/1ns
`include "sb_defs.svh"

module scoreboard_top (
    input  logic                  clk,
    input  logic                  rst,
    input  sb_pkg::inst_t         inst,
    input  logic                  inst_valid,
    output logic                  inst_ready,
    input  logic [`SB_NUM_FU-1:0] fu_done,
    input  logic                  jump_taken,
    output logic                  ro_valid,
    output sb_pkg::ro_t           ro,
    output logic                  wb_valid,
    output sb_pkg::wb_t           wb,
    output logic                  flush
);

    sb_pkg::decoded_t                   dec;
    sb_pkg::fu_id_t                     prod1;
    sb_pkg::fu_id_t                     prod2;
    sb_pkg::fu_id_t                     dst_prod;
    logic                               issue_en;
    sb_pkg::fu_entry_t [`SB_NUM_FU-1:0] entries;
    logic [`SB_NUM_FU-1:0]              busy;
    logic [`SB_NUM_FU-1:0]              grant;
    logic [`SB_NUM_FU-1:0]              retire;
    sb_pkg::fu_id_t                     retire_fu;

    inst_decoder u_decoder (
        .inst (inst),
        .dec  (dec)
    );

    reg_status u_reg_status (
        .clk       (clk),
        .rst       (rst),
        .src1      (dec.src1),
        .src2      (dec.src2),
        .dst       (dec.dst),
        .prod1     (prod1),
        .prod2     (prod2),
        .dst_prod  (dst_prod),
        .issue_en  (issue_en),
        .issue_fu  (dec.fu),
        .retire_fu (retire_fu),
        .retire_rd (wb.rd)
    );

    // one status entry per unit, index i holds unit i + 1
    for (genvar i = 0; i < `SB_NUM_FU; i++) begin : g_fu
        fu_status #(
            .FU_ID (sb_pkg::fu_id_t'(i + 1))
        ) u_fu_status (
            .clk       (clk),
            .rst       (rst),
            .issue_en  (issue_en),
            .dec       (dec),
            .prod1     (prod1),
            .prod2     (prod2),
            .grant     (grant[i]),
            .done      (fu_done[i]),
            .retire    (retire[i]),
            .retire_fu (retire_fu),
            .entry     (entries[i])
        );
        assign busy[i] = entries[i].busy;
    end

    issue_ctrl u_issue_ctrl (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .dec        (dec),
        .dst_prod   (dst_prod),
        .busy       (busy),
        .jump_done  (fu_done[sb_pkg::FU_JUMP - 1]),
        .jump_taken (jump_taken),
        .inst_ready (inst_ready),
        .issue_en   (issue_en),
        .flush      (flush)
    );

    read_arbiter u_read_arbiter (
        .entries  (entries),
        .grant    (grant),
        .ro_valid (ro_valid),
        .ro       (ro)
    );

    writeback_ctrl u_writeback_ctrl (
        .entries   (entries),
        .retire    (retire),
        .retire_fu (retire_fu),
        .wb_valid  (wb_valid),
        .wb        (wb)
    );

endmodule

// ==== bench/sb_model.svh ====
`ifndef SB_MODEL_SVH
`define SB_MODEL_SVH

// shadow scoreboard arrays indexed by unit number with slot 0 unused
logic             m_busy  [0:5];
logic             m_disp  [0:5];
logic             m_done  [0:5];
sb_pkg::decoded_t m_dec   [0:5];
sb_pkg::fu_id_t   m_wait1 [0:5];
sb_pkg::fu_id_t   m_wait2 [0:5];
sb_pkg::fu_id_t   m_pend  [32];
logic             m_jstall;
logic             m_flush;

// regs selects which of rd, rs1, rs2 are used
function automatic sb_pkg::decoded_t pack_dec(input sb_pkg::fu_id_t fu, input int op,
                                              input logic [2:0] regs, input sb_pkg::inst_t w);
    sb_pkg::decoded_t d;
    d.fu   = fu;
    d.op   = sb_pkg::op_code_t'(op);
    d.dst  = regs[2] ? w[11:7] : 5'd0;
    d.src1 = regs[1] ? w[19:15] : 5'd0;
    d.src2 = regs[0] ? w[24:20] : 5'd0;
    return d;
endfunction

// key is funct7, funct3, opcode
function automatic sb_pkg::decoded_t model_decode(input sb_pkg::inst_t w);
    sb_pkg::decoded_t d;
    d = '0;
    casez ({w[31:25], w[14:12], w[6:0]})
        17'b0000000_000_0110011: d = pack_dec(sb_pkg::FU_ALU, 0, 3'b111, w);
        17'b0100000_000_0110011: d = pack_dec(sb_pkg::FU_ALU, 1, 3'b111, w);
        17'b0000000_111_0110011: d = pack_dec(sb_pkg::FU_ALU, 2, 3'b111, w);
        17'b0000000_110_0110011: d = pack_dec(sb_pkg::FU_ALU, 3, 3'b111, w);
        17'b0000000_100_0110011: d = pack_dec(sb_pkg::FU_ALU, 4, 3'b111, w);
        17'b0000000_001_0110011: d = pack_dec(sb_pkg::FU_ALU, 5, 3'b111, w);
        17'b0000000_101_0110011: d = pack_dec(sb_pkg::FU_ALU, 6, 3'b111, w);
        17'b0000000_010_0110011: d = pack_dec(sb_pkg::FU_ALU, 7, 3'b111, w);
        17'b0000000_011_0110011: d = pack_dec(sb_pkg::FU_ALU, 8, 3'b111, w);
        17'b0100000_101_0110011: d = pack_dec(sb_pkg::FU_ALU, 9, 3'b111, w);
        17'b???????_???_0110111: d = pack_dec(sb_pkg::FU_ALU, 10, 3'b100, w);
        17'b???????_???_0010111: d = pack_dec(sb_pkg::FU_ALU, 11, 3'b100, w);
        17'b???????_000_0010011: d = pack_dec(sb_pkg::FU_ALU, 12, 3'b110, w);
        17'b???????_111_0010011: d = pack_dec(sb_pkg::FU_ALU, 13, 3'b110, w);
        17'b???????_110_0010011: d = pack_dec(sb_pkg::FU_ALU, 14, 3'b110, w);
        17'b???????_100_0010011: d = pack_dec(sb_pkg::FU_ALU, 15, 3'b110, w);
        17'b0000000_001_0010011: d = pack_dec(sb_pkg::FU_ALU, 16, 3'b110, w);
        17'b0000000_101_0010011: d = pack_dec(sb_pkg::FU_ALU, 17, 3'b110, w);
        17'b???????_010_0010011: d = pack_dec(sb_pkg::FU_ALU, 18, 3'b110, w);
        17'b???????_011_0010011: d = pack_dec(sb_pkg::FU_ALU, 19, 3'b110, w);
        17'b0100000_101_0010011: d = pack_dec(sb_pkg::FU_ALU, 20, 3'b110, w);
        17'b???????_000_0000011: d = pack_dec(sb_pkg::FU_MEM, 0, 3'b110, w);
        17'b???????_001_0000011: d = pack_dec(sb_pkg::FU_MEM, 1, 3'b110, w);
        17'b???????_010_0000011: d = pack_dec(sb_pkg::FU_MEM, 2, 3'b110, w);
        17'b???????_100_0000011: d = pack_dec(sb_pkg::FU_MEM, 3, 3'b110, w);
        17'b???????_101_0000011: d = pack_dec(sb_pkg::FU_MEM, 4, 3'b110, w);
        17'b???????_000_0100011: d = pack_dec(sb_pkg::FU_MEM, 5, 3'b011, w);
        17'b???????_001_0100011: d = pack_dec(sb_pkg::FU_MEM, 6, 3'b011, w);
        17'b???????_010_0100011: d = pack_dec(sb_pkg::FU_MEM, 7, 3'b011, w);
        // mul and div ops follow funct3 order
        17'b0000001_0??_0110011: d = pack_dec(sb_pkg::FU_MUL, w[13:12], 3'b111, w);
        17'b0000001_1??_0110011: d = pack_dec(sb_pkg::FU_DIV, w[13:12], 3'b111, w);
        17'b???????_000_1100011: d = pack_dec(sb_pkg::FU_JUMP, 0, 3'b011, w);
        17'b???????_001_1100011: d = pack_dec(sb_pkg::FU_JUMP, 1, 3'b011, w);
        17'b???????_100_1100011: d = pack_dec(sb_pkg::FU_JUMP, 2, 3'b011, w);
        17'b???????_101_1100011: d = pack_dec(sb_pkg::FU_JUMP, 3, 3'b011, w);
        17'b???????_110_1100011: d = pack_dec(sb_pkg::FU_JUMP, 4, 3'b011, w);
        17'b???????_111_1100011: d = pack_dec(sb_pkg::FU_JUMP, 5, 3'b011, w);
        17'b???????_???_1101111: d = pack_dec(sb_pkg::FU_JUMP, 6, 3'b100, w);
        17'b???????_000_1100111: d = pack_dec(sb_pkg::FU_JUMP, 7, 3'b110, w);
        default: d = '0;
    endcase
    return d;
endfunction

// JUMP first, then ALU, MEM, MUL, DIV
function automatic sb_pkg::fu_id_t pick_first(input logic [5:0] req);
    sb_pkg::fu_id_t order [5];
    sb_pkg::fu_id_t pick;
    order = '{sb_pkg::FU_JUMP, sb_pkg::FU_ALU, sb_pkg::FU_MEM,
              sb_pkg::FU_MUL, sb_pkg::FU_DIV};
    pick = sb_pkg::FU_NONE;
    for (int k = 4; k >= 0; k--) begin
        if (req[order[k]]) begin
            pick = order[k];
        end
    end
    return pick;
endfunction

function automatic sb_pkg::fu_id_t expected_ro();
    logic [5:0] req;
    req = '0;
    for (int f = 1; f <= 5; f++) begin
        req[f] = m_busy[f] && !m_disp[f] && m_wait1[f] == sb_pkg::FU_NONE &&
                 m_wait2[f] == sb_pkg::FU_NONE;
    end
    return pick_first(req);
endfunction

// a done unit waits while an unread ready operand still names its rd
function automatic sb_pkg::fu_id_t expected_wb();
    logic [5:0] ok;
    logic       reads;
    ok = '0;
    for (int f = 1; f <= 5; f++) begin
        ok[f] = m_done[f];
        for (int g = 1; g <= 5; g++) begin
            reads = (m_wait1[g] == sb_pkg::FU_NONE && m_dec[g].src1 == m_dec[f].dst) ||
                    (m_wait2[g] == sb_pkg::FU_NONE && m_dec[g].src2 == m_dec[f].dst);
            if (g != f && m_busy[g] && !m_disp[g] && reads) begin
                ok[f] = 1'b0;
            end
        end
    end
    return pick_first(ok);
endfunction

function automatic logic units_busy();
    logic any;
    any = 1'b0;
    for (int f = 1; f <= 5; f++) begin
        any = any || m_busy[f];
    end
    return any;
endfunction

task automatic reset_model();
    for (int f = 0; f <= 5; f++) begin
        m_busy[f]  = 1'b0;
        m_disp[f]  = 1'b0;
        m_done[f]  = 1'b0;
        m_dec[f]   = '0;
        m_wait1[f] = sb_pkg::FU_NONE;
        m_wait2[f] = sb_pkg::FU_NONE;
    end
    for (int r = 0; r < 32; r++) begin
        m_pend[r] = sb_pkg::FU_NONE;
    end
    m_jstall = 1'b0;
    m_flush  = 1'b0;
endtask

`endif

// ==== bench/scoreboard_tb.sv ====
`timescale 1ns/1ns
`include "sb_defs.svh"

module scoreboard_tb;

    localparam int NUM_INST        = 2000;
    localparam int CYCLES_PER_INST = 20;
    localparam int CLK_PERIOD      = 8;

    logic                  clk;
    logic                  rst;
    sb_pkg::inst_t         inst;
    logic                  inst_valid;
    logic                  inst_ready;
    logic [`SB_NUM_FU-1:0] fu_done;
    logic                  jump_taken;
    logic                  ro_valid;
    sb_pkg::ro_t           ro;
    logic                  wb_valid;
    sb_pkg::wb_t           wb;
    logic                  flush;

    integer     seed;
    int         accepted;
    logic       take_new;
    int         countdown [0:5];
    logic [6:0] opcodes [9];

    `include "sb_model.svh"

    scoreboard_top DUT (
        .clk        (clk),
        .rst        (rst),
        .inst       (inst),
        .inst_valid (inst_valid),
        .inst_ready (inst_ready),
        .fu_done    (fu_done),
        .jump_taken (jump_taken),
        .ro_valid   (ro_valid),
        .ro         (ro),
        .wb_valid   (wb_valid),
        .wb         (wb),
        .flush      (flush)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #(NUM_INST * CYCLES_PER_INST * CLK_PERIOD);
        $display("Timeout: the run did not finish in the allowed time");
        $display("TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    task automatic expect_equal(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        assert (act === exp) else begin
            $display("Error: %s expected %0h actual %0h", name, exp, act);
            $display("TESTS FAILED");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // registers limited to x0..x7 so hazards are frequent
    function automatic sb_pkg::inst_t random_word();
        sb_pkg::inst_t w;
        int            f7_pick;
        w = $random(seed);
        // one word in eight stays fully random and mostly unrecognised
        if (($random(seed) & 7) != 0) begin
            w[6:0]   = opcodes[$unsigned($random(seed)) % 9];
            f7_pick  = $unsigned($random(seed)) % 3;
            w[31:25] = (f7_pick == 0) ? 7'h00 : (f7_pick == 1) ? 7'h20 : 7'h01;
            w[11:7]  = $unsigned($random(seed)) % 8;
            w[19:15] = $unsigned($random(seed)) % 8;
            w[24:20] = $unsigned($random(seed)) % 8;
        end
        return w;
    endfunction

    task automatic drive_inputs(input logic sending);
        fu_done = '0;
        for (int f = 1; f <= 5; f++) begin
            if (countdown[f] > 0) begin
                countdown[f]--;
                if (countdown[f] == 0) begin
                    fu_done[f-1] = 1'b1;
                end
            end
        end
        jump_taken = ($random(seed) % 2) != 0;
        if (take_new) begin
            inst_valid = sending && (($random(seed) & 3) != 0);
            inst       = random_word();
        end
    endtask

    task automatic retire_in_model(input sb_pkg::fu_id_t f);
        m_pend[m_dec[f].dst] = sb_pkg::FU_NONE;
        for (int g = 1; g <= 5; g++) begin
            if (m_wait1[g] == f) begin
                m_wait1[g] = sb_pkg::FU_NONE;
            end
            if (m_wait2[g] == f) begin
                m_wait2[g] = sb_pkg::FU_NONE;
            end
        end
        m_busy[f] = 1'b0;
        m_disp[f] = 1'b0;
        m_done[f] = 1'b0;
    endtask

    task automatic issue_in_model(input sb_pkg::decoded_t d);
        m_busy[d.fu]  = 1'b1;
        m_disp[d.fu]  = 1'b0;
        m_done[d.fu]  = 1'b0;
        m_dec[d.fu]   = d;
        m_wait1[d.fu] = m_pend[d.src1];
        m_wait2[d.fu] = m_pend[d.src2];
        if (d.dst != 0) begin
            m_pend[d.dst] = d.fu;
        end
        if (d.fu == sb_pkg::FU_JUMP) begin
            m_jstall = 1'b1;
        end
    endtask

    // compare outputs, then move the model across the coming edge
    task automatic check_and_advance();
        sb_pkg::decoded_t d;
        sb_pkg::fu_id_t   exp_ro_fu;
        sb_pkg::fu_id_t   exp_wb_fu;
        logic             exp_ready;
        logic             jump_done;
        d = model_decode(inst);
        exp_ready = m_flush || !((d.fu != sb_pkg::FU_NONE && m_busy[d.fu]) ||
                                 (d.dst != 0 && m_pend[d.dst] != sb_pkg::FU_NONE) || m_jstall);
        expect_equal("inst_ready", exp_ready, inst_ready);
        expect_equal("flush", m_flush, flush);
        exp_ro_fu = expected_ro();
        // a reader dispatching this cycle still holds off a WAR write-back
        exp_wb_fu = expected_wb();
        expect_equal("ro_valid", exp_ro_fu != sb_pkg::FU_NONE, ro_valid);
        if (ro_valid) begin
            expect_equal("ro.fu", exp_ro_fu, ro.fu);
            expect_equal("ro.op", m_dec[exp_ro_fu].op, ro.op);
            expect_equal("ro.rs1", m_dec[exp_ro_fu].src1, ro.rs1);
            expect_equal("ro.rs2", m_dec[exp_ro_fu].src2, ro.rs2);
            m_disp[exp_ro_fu]    = 1'b1;
            countdown[exp_ro_fu] = 1 + $unsigned($random(seed)) % 6;
        end
        expect_equal("wb_valid", exp_wb_fu != sb_pkg::FU_NONE, wb_valid);
        if (wb_valid) begin
            expect_equal("wb.fu", exp_wb_fu, wb.fu);
            expect_equal("wb.rd", m_dec[exp_wb_fu].dst, wb.rd);
            retire_in_model(exp_wb_fu);
        end
        for (int f = 1; f <= 5; f++) begin
            if (fu_done[f-1]) begin
                m_done[f] = 1'b1;
            end
        end
        jump_done = fu_done[sb_pkg::FU_JUMP - 1];
        if (jump_done) begin
            m_jstall = 1'b0;
        end
        if (inst_valid && inst_ready && !m_flush && d.fu != sb_pkg::FU_NONE) begin
            issue_in_model(d);
        end
        m_flush  = jump_done && jump_taken;
        take_new = !inst_valid || inst_ready;
        if (inst_valid && inst_ready) begin
            accepted++;
        end
    endtask

    initial begin
        seed       = 37096;
        clk        = 1'b0;
        rst        = 1'b1;
        inst       = '0;
        inst_valid = 1'b0;
        fu_done    = '0;
        jump_taken = 1'b0;
        accepted   = 0;
        take_new   = 1'b1;
        opcodes    = '{7'h33, 7'h13, 7'h03, 7'h23, 7'h63, 7'h37, 7'h17, 7'h6f, 7'h67};
        for (int f = 0; f <= 5; f++) begin
            countdown[f] = 0;
        end
        reset_model();
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        expect_equal("reset inst_ready", 1'b1, inst_ready);
        expect_equal("reset ro_valid", 1'b0, ro_valid);
        expect_equal("reset wb_valid", 1'b0, wb_valid);
        expect_equal("reset flush", 1'b0, flush);
        // random traffic, then drain until every unit has written back
        while (accepted < NUM_INST || units_busy()) begin
            @(posedge clk);
            #1;
            drive_inputs(accepted < NUM_INST);
            @(negedge clk);
            check_and_advance();
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+hdl
+incdir+bench
hdl/sb_pkg.sv
hdl/inst_decoder.sv
hdl/reg_status.sv
hdl/fu_status.sv
hdl/issue_ctrl.sv
hdl/read_arbiter.sv
hdl/writeback_ctrl.sv
hdl/scoreboard_top.sv
bench/scoreboard_tb.sv
